/* hw/dma_width_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_width_fifo
    import hbm_write_pkg::*;
(
    input  logic                  hbm_clk,
    input  logic                  hbm_aresetn,
    input  logic                  dma_data_valid,
    input  logic [dma_data_w-1:0] dma_data,
    output logic                  dma_data_ready,
    input  logic                  rd_en,
    output logic [hbm_data_w-1:0] rd_data,
    output logic                  empty
);

    logic [dma_data_w-1:0] mem [fifo_depth];
    logic [dma_data_w-1:0] wr_data_q;
    logic                  wr_en_q;
    logic [fifo_ptr_w:0]   wr_ptr, rd_ptr;  // extra bit tells full from empty
    logic [fifo_ptr_w:0]   used;
    logic                  half_sel;        // 0 = low half next

    assign used           = wr_ptr - rd_ptr;
    assign empty          = (used == '0);
    assign dma_data_ready = (used < (fifo_ptr_w + 1)'(fifo_depth - fifo_slack));

    // head entry, low half first
    assign rd_data = half_sel ? mem[rd_ptr[fifo_ptr_w-1:0]][dma_data_w-1:hbm_data_w]
                              : mem[rd_ptr[fifo_ptr_w-1:0]][hbm_data_w-1:0];

    ////////////////////////////////////////
    // write side, one cycle behind dma
    ////////////////////////////////////////
    always_ff @(posedge hbm_clk) begin
        wr_data_q <= dma_data;
        if (wr_en_q) mem[wr_ptr[fifo_ptr_w-1:0]] <= wr_data_q;
    end

    always_ff @(posedge hbm_clk) begin
        if (!hbm_aresetn) begin
            wr_en_q  <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            half_sel <= 1'b0;
        end else begin
            wr_en_q <= dma_data_valid & dma_data_ready;
            if (wr_en_q) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) begin
                half_sel <= ~half_sel;
                if (half_sel) rd_ptr <= rd_ptr + 1'b1;   // entry freed after high half
            end
        end
    end

endmodule

`default_nettype wire

/* hw/hbm_a_layout_walker.sv */
`timescale 1ns/1ps
`default_nettype none

module hbm_a_layout_walker
    import hbm_write_pkg::*;
(
    input  logic                  hbm_clk,
    input  logic                  hbm_aresetn,
    input  logic                  job_start,
    input  logic                  walker_load,
    input  logic                  walker_step,
    input  logic [31:0]           dimension,
    input  logic [31:0]           number_of_samples,
    input  logic [31:0]           number_of_bits,
    input  logic [31:0]           araddr_stride,
    output logic [hbm_addr_w-1:0] a_burst_addr,
    output logic                  a_done,
    output logic                  walker_chan_wrap
);

    logic [31:0]         dim_align;
    logic [31:0]         feat_cnt, samp_cnt;
    logic [7:0]          bit_cnt;
    logic [chan_w-1:0]   chan_cnt;
    logic [chan_lsb-1:0] base_addr;     // pass base, below channel field
    logic                feat_last, samp_last, chan_last, bit_last;

    // dimension rounded up to whole feature groups
    assign dim_align = (dimension + 32'(features_per_burst - 1))
                       & ~32'(features_per_burst - 1);

    assign feat_last = (feat_cnt + features_per_burst >= dim_align);
    assign samp_last = (samp_cnt + a_samples_per_burst >= number_of_samples);
    assign chan_last = (chan_cnt == chan_w'(chan_num - 1));
    assign bit_last  = (32'(bit_cnt) + bits_per_pass >= number_of_bits);

    assign walker_chan_wrap = feat_last & samp_last;   // last burst of this channel
    assign a_done           = walker_chan_wrap & chan_last & bit_last;
    assign a_burst_addr     = {(hbm_addr_w - chan_lsb)'(chan_cnt), base_addr};

    always_ff @(posedge hbm_clk) begin
        if (!hbm_aresetn || job_start) begin
            feat_cnt  <= '0;
            samp_cnt  <= '0;
            chan_cnt  <= '0;
            bit_cnt   <= '0;
            base_addr <= '0;
        end else begin
            if (walker_load && chan_last)
                base_addr <= base_addr + araddr_stride[chan_lsb-1:0]; // next pass
            if (walker_step) begin
                feat_cnt <= feat_last ? '0 : feat_cnt + features_per_burst;
                if (feat_last)
                    samp_cnt <= samp_last ? '0 : samp_cnt + a_samples_per_burst;
                if (walker_chan_wrap) begin
                    chan_cnt <= chan_last ? '0 : chan_cnt + 1'b1;
                    if (chan_last)
                        bit_cnt <= bit_last ? '0 : bit_cnt + 8'(bits_per_pass);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/hbm_aw_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module hbm_aw_gen
    import hbm_write_pkg::*;
(
    input  logic                  hbm_clk,
    input  logic                  hbm_aresetn,
    input  logic                  start,
    input  logic [dma_addr_w-1:0] dma_addr_a,
    input  logic [dma_addr_w-1:0] dma_addr_b,
    input  logic [31:0]           data_a_length,
    input  logic [31:0]           data_b_length,
    input  logic [hbm_addr_w-1:0] hbm_addr_b,
    input  logic [31:0]           number_of_samples,
    output logic                  dma_cmd_valid,
    output logic [dma_addr_w-1:0] dma_cmd_address,
    output logic [31:0]           dma_cmd_length,
    input  logic                  dma_cmd_ready,
    output logic                  hbm_awvalid,
    output logic [hbm_addr_w-1:0] hbm_awaddr,
    input  logic                  hbm_awready,
    output logic                  job_start,
    output logic                  walker_load,
    output logic                  walker_step,
    input  logic [hbm_addr_w-1:0] a_burst_addr,
    input  logic                  a_done,
    input  logic                  walker_chan_wrap
);

    addr_state_t state, state_nxt;
    logic        start_d0;
    logic [31:0] b_burst_cnt;
    logic [31:0] b_bursts;
    logic        cmd_fire, aw_fire;

    assign b_bursts = number_of_samples >> $clog2(b_samples_per_burst);

    assign dma_cmd_valid = (state == send_b_cmd) || (state == send_a_cmd);
    assign hbm_awvalid   = (state == write_b_addr) || (state == write_a_addr);
    assign cmd_fire      = dma_cmd_valid & dma_cmd_ready;
    assign aw_fire       = hbm_awvalid & hbm_awready;
    assign walker_load   = (state == load_a_addr);
    assign walker_step   = (state == write_a_addr) & hbm_awready;

    always_ff @(posedge hbm_clk) begin
        if (!hbm_aresetn) begin
            start_d0  <= 1'b0;
            job_start <= 1'b0;
            state     <= idle;
        end else begin
            start_d0  <= start;
            job_start <= start_d0;  // two flops behind start
            state     <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            idle:         if (job_start) state_nxt = send_b_cmd;
            send_b_cmd:   if (cmd_fire) state_nxt = load_b_addr;
            load_b_addr:  state_nxt = write_b_addr;
            write_b_addr: if (aw_fire && b_burst_cnt == b_bursts - 1) state_nxt = send_a_cmd;
            send_a_cmd:   if (cmd_fire) state_nxt = load_a_addr;
            load_a_addr:  state_nxt = write_a_addr;
            write_a_addr: begin
                if (aw_fire && a_done)
                    state_nxt = write_end;
                else if (aw_fire && walker_chan_wrap)
                    state_nxt = load_a_addr;    // next channel
            end
            write_end:    state_nxt = idle;
            default:      state_nxt = idle;
        endcase
    end

    // command payload and burst address
    always_ff @(posedge hbm_clk) begin
        if (state == idle && job_start) begin
            dma_cmd_address <= dma_addr_b;
            dma_cmd_length  <= data_b_length;
            b_burst_cnt     <= '0;
        end
        if (state == write_b_addr) begin
            dma_cmd_address <= dma_addr_a;  // ready for the A command
            dma_cmd_length  <= data_a_length;
        end
        if (state == load_b_addr) hbm_awaddr <= hbm_addr_b;
        if (state == load_a_addr) hbm_awaddr <= a_burst_addr;  // channel start
        if (aw_fire) begin
            hbm_awaddr  <= hbm_awaddr + hbm_addr_w'(burst_bytes);
            b_burst_cnt <= b_burst_cnt + 32'd1;
        end
    end

endmodule

`default_nettype wire

/* hw/hbm_w_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module hbm_w_ctrl
    import hbm_write_pkg::*;
(
    input  logic        hbm_clk,
    input  logic        hbm_aresetn,
    input  logic        job_start,
    input  logic [31:0] data_a_length,
    input  logic [31:0] data_b_length,
    input  logic        fifo_empty,
    output logic        fifo_rd_en,
    output logic        hbm_wvalid,
    output logic        hbm_wlast,
    input  logic        hbm_wready,
    output logic        hbm_write_done
);

    data_state_t       state, state_nxt;
    logic [beat_w-1:0] beat_cnt;
    logic [31:0]       burst_cnt;
    logic [31:0]       bursts_m1;     // bursts in this phase minus one
    logic              w_fire, phase_end;

    assign hbm_wvalid     = ((state == w_b_data) || (state == w_a_data)) & ~fifo_empty;
    assign hbm_wlast      = hbm_wvalid & (beat_cnt == beat_w'(burst_beats - 1));
    assign w_fire         = hbm_wvalid & hbm_wready;
    assign fifo_rd_en     = w_fire;
    assign phase_end      = w_fire & hbm_wlast & (burst_cnt == bursts_m1);
    assign hbm_write_done = (state == w_end);

    always_comb begin
        state_nxt = state;
        case (state)
            w_idle:   if (job_start) state_nxt = w_b_wait;
            w_b_wait: if (!fifo_empty) state_nxt = w_b_data;
            w_b_data: if (phase_end) state_nxt = w_gap;
            w_gap:    state_nxt = w_a_wait;    // A count loads here
            w_a_wait: if (!fifo_empty) state_nxt = w_a_data;
            w_a_data: if (phase_end) state_nxt = w_end;
            w_end:    state_nxt = w_idle;
            default:  state_nxt = w_idle;
        endcase
    end

    always_ff @(posedge hbm_clk) begin
        if (!hbm_aresetn) begin
            state     <= w_idle;
            beat_cnt  <= '0;
            burst_cnt <= '0;
            bursts_m1 <= '0;
        end else begin
            state <= state_nxt;
            if (state == w_idle && job_start)
                bursts_m1 <= (data_b_length >> $clog2(burst_bytes)) - 32'd1;
            else if (state == w_gap)
                bursts_m1 <= (data_a_length >> $clog2(burst_bytes)) - 32'd1;
            if (w_fire) begin
                beat_cnt <= hbm_wlast ? '0 : beat_cnt + 1'b1;
                if (hbm_wlast)
                    burst_cnt <= phase_end ? '0 : burst_cnt + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/hbm_wr_stats.sv */
`timescale 1ns/1ps
`default_nettype none

module hbm_wr_stats (
    input  logic        hbm_clk,
    input  logic        hbm_aresetn,
    input  logic        job_start,
    input  logic        hbm_write_done,
    input  logic        aw_fire,
    input  logic        w_fire,
    output logic [31:0] hbm_write_cycle_cnt,
    output logic [31:0] hbm_write_addr_cnt,
    output logic [31:0] hbm_write_data_cnt
);

    logic        running;
    logic [31:0] cycle_cnt, addr_cnt, data_cnt;

    always_ff @(posedge hbm_clk) begin
        if (!hbm_aresetn) begin
            running   <= 1'b0;
            cycle_cnt <= '0;
            addr_cnt  <= '0;
            data_cnt  <= '0;
            hbm_write_cycle_cnt <= '0;
            hbm_write_addr_cnt  <= '0;
            hbm_write_data_cnt  <= '0;
        end else begin
            if (job_start) begin
                running   <= 1'b1;
                cycle_cnt <= '0;
                addr_cnt  <= '0;
                data_cnt  <= '0;
            end else begin
                if (hbm_write_done) running <= 1'b0;
                if (running) cycle_cnt <= cycle_cnt + 32'd1;
                if (aw_fire) addr_cnt <= addr_cnt + 32'd1;
                if (w_fire) data_cnt <= data_cnt + 32'd1;
            end
            hbm_write_cycle_cnt <= cycle_cnt;   // one cycle behind
            hbm_write_addr_cnt  <= addr_cnt;
            hbm_write_data_cnt  <= data_cnt;
        end
    end

endmodule

`default_nettype wire

/* hw/hbm_write_pkg.sv */
`default_nettype none

package hbm_write_pkg;

    ////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////
    localparam int hbm_addr_w  = 33;    // 8 GB byte address
    localparam int dma_addr_w  = 64;
    localparam int dma_data_w  = 512;
    localparam int hbm_data_w  = 256;
    localparam int burst_beats = 2;     // awlen + 1
    localparam int burst_bytes = 64;    // one burst = one dma word
    localparam int fifo_depth  = 16;    // 512-bit entries
    localparam int fifo_slack  = 4;     // room for words still in flight

    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int beat_w     = $clog2(burst_beats);

    ////////////////////////////////////////
    // banked layout of matrix A
    ////////////////////////////////////////
    localparam int chan_num            = 8;
    localparam int chan_lsb            = 28;   // channel sits above this bit
    localparam int chan_w              = $clog2(chan_num);
    localparam int b_samples_per_burst = 16;
    localparam int a_samples_per_burst = 8;
    localparam int features_per_burst  = 64;
    localparam int bits_per_pass       = 2;

    typedef enum logic [2:0] {
        idle, send_b_cmd, load_b_addr, write_b_addr,
        send_a_cmd, load_a_addr, write_a_addr, write_end
    } addr_state_t;

    typedef enum logic [2:0] {
        w_idle, w_b_wait, w_b_data, w_gap, w_a_wait, w_a_data, w_end
    } data_state_t;

endpackage

`default_nettype wire

/* hw/hbm_write_top.sv */
`timescale 1ns/1ps
`default_nettype none

module hbm_write_top
    import hbm_write_pkg::*;
(
    input  logic                  hbm_clk,
    input  logic                  hbm_aresetn,
    input  logic                  start,
    input  logic [31:0]           data_a_length,    // bytes, multiple of 64
    input  logic [31:0]           data_b_length,
    input  logic [dma_addr_w-1:0] dma_addr_a,
    input  logic [dma_addr_w-1:0] dma_addr_b,
    input  logic [hbm_addr_w-1:0] hbm_addr_b,
    input  logic [31:0]           number_of_samples,
    input  logic [31:0]           dimension,
    input  logic [31:0]           number_of_bits,
    input  logic [31:0]           araddr_stride,
    // dma read command
    output logic                  dma_cmd_valid,
    output logic [dma_addr_w-1:0] dma_cmd_address,
    output logic [31:0]           dma_cmd_length,
    input  logic                  dma_cmd_ready,
    // dma read data
    input  logic                  dma_data_valid,
    input  logic [dma_data_w-1:0] dma_data,
    output logic                  dma_data_ready,
    // hbm write address / data
    output logic                  hbm_awvalid,
    output logic [hbm_addr_w-1:0] hbm_awaddr,
    input  logic                  hbm_awready,
    output logic                  hbm_wvalid,
    output logic [hbm_data_w-1:0] hbm_wdata,
    output logic                  hbm_wlast,
    input  logic                  hbm_wready,
    output logic                  hbm_write_done,
    output logic [31:0]           hbm_write_cycle_cnt,
    output logic [31:0]           hbm_write_addr_cnt,
    output logic [31:0]           hbm_write_data_cnt
);

    logic                  job_start;
    logic                  walker_load, walker_step;
    logic [hbm_addr_w-1:0] a_burst_addr;
    logic                  a_done, walker_chan_wrap;
    logic                  fifo_rd_en, fifo_empty;

    hbm_aw_gen u_aw_gen (
        .hbm_clk, .hbm_aresetn, .start,
        .dma_addr_a, .dma_addr_b, .data_a_length, .data_b_length,
        .hbm_addr_b, .number_of_samples,
        .dma_cmd_valid, .dma_cmd_address, .dma_cmd_length, .dma_cmd_ready,
        .hbm_awvalid, .hbm_awaddr, .hbm_awready,
        .job_start, .walker_load, .walker_step,
        .a_burst_addr, .a_done, .walker_chan_wrap
    );

    hbm_a_layout_walker u_walker (
        .hbm_clk, .hbm_aresetn, .job_start, .walker_load, .walker_step,
        .dimension, .number_of_samples, .number_of_bits, .araddr_stride,
        .a_burst_addr, .a_done, .walker_chan_wrap
    );

    // 512 in, two 256 beats out
    dma_width_fifo u_fifo (
        .hbm_clk, .hbm_aresetn,
        .dma_data_valid, .dma_data, .dma_data_ready,
        .rd_en   (fifo_rd_en),
        .rd_data (hbm_wdata),
        .empty   (fifo_empty)
    );

    hbm_w_ctrl u_w_ctrl (
        .hbm_clk, .hbm_aresetn, .job_start, .data_a_length, .data_b_length,
        .fifo_empty, .fifo_rd_en,
        .hbm_wvalid, .hbm_wlast, .hbm_wready, .hbm_write_done
    );

    hbm_wr_stats u_stats (
        .hbm_clk, .hbm_aresetn, .job_start, .hbm_write_done,
        .aw_fire (hbm_awvalid & hbm_awready),
        .w_fire  (hbm_wvalid & hbm_wready),
        .hbm_write_cycle_cnt, .hbm_write_addr_cnt, .hbm_write_data_cnt
    );

endmodule

`default_nettype wire

/* sim/tb_hbm_write.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_hbm_write
    import hbm_write_pkg::*;
();

    ////////////////////////////////////////
    // job shape, same for both jobs
    ////////////////////////////////////////
    localparam int num_jobs   = 2;
    localparam int num_samp   = 32;     // one input, B and A share it
    localparam int a_dim      = 64;
    localparam int a_bits     = 4;
    localparam int b_bursts   = num_samp / b_samples_per_burst;
    localparam int a_per_chan = ((a_dim + features_per_burst - 1) / features_per_burst)
                              * ((num_samp + a_samples_per_burst - 1) / a_samples_per_burst);
    localparam int a_passes   = (a_bits + bits_per_pass - 1) / bits_per_pass;
    localparam int a_bursts   = a_per_chan * chan_num * a_passes;
    localparam int job_bursts = b_bursts + a_bursts;
    localparam int job_beats  = job_bursts * burst_beats;
    localparam int timeout_cycles = 8 * num_jobs * (job_bursts + job_beats) + 200;
    localparam logic [hbm_addr_w-1:0] low_mask = (hbm_addr_w'(1) << chan_lsb) - hbm_addr_w'(1);

    logic                  hbm_clk, hbm_aresetn, start;
    logic [31:0]           data_a_length, data_b_length;
    logic [dma_addr_w-1:0] dma_addr_a, dma_addr_b;
    logic [hbm_addr_w-1:0] hbm_addr_b;
    logic [31:0]           number_of_samples, dimension, number_of_bits, araddr_stride;
    logic                  dma_cmd_valid, dma_cmd_ready;
    logic [dma_addr_w-1:0] dma_cmd_address;
    logic [31:0]           dma_cmd_length;
    logic                  dma_data_valid, dma_data_ready;
    logic [dma_data_w-1:0] dma_data;
    logic                  hbm_awvalid, hbm_awready;
    logic [hbm_addr_w-1:0] hbm_awaddr;
    logic                  hbm_wvalid, hbm_wlast, hbm_wready;
    logic [hbm_data_w-1:0] hbm_wdata;
    logic                  hbm_write_done;
    logic [31:0]           hbm_write_cycle_cnt, hbm_write_addr_cnt, hbm_write_data_cnt;

    integer seed = 32'he7fe_e65d;
    int     errors = 0;
    int     cycles = 0;
    int     cmds_seen = 0;
    int     addrs_seen = 0;
    int     beats_seen = 0;
    int     done_cnt = 0;
    int     beat_goal = 0;          // beats expected by the end of the current job
    logic   done_due = 1'b0;
    logic   dma_fire_n = 1'b0;      // data handshake seen at the last negedge
    int     fifo_used = 0;          // entries written and not yet freed
    logic   dma_wr_due = 1'b0;      // word taken last cycle, lands at the next edge
    int     words_left, word_idx;

    logic [dma_addr_w-1:0] cmd_addr_q[$];
    logic [31:0]           cmd_len_q[$];
    int                    word_q[$];     // words owed per accepted command
    logic [hbm_addr_w-1:0] addr_q[$];
    logic [hbm_data_w-1:0] beat_q[$];
    logic [dma_addr_w-1:0] exp_cmd_addr;
    logic [31:0]           exp_cmd_len;
    logic [hbm_addr_w-1:0] exp_addr;
    logic [hbm_data_w-1:0] exp_beat;
    logic                  exp_last;
    logic                  exp_ready;

    hbm_write_top DUT (.*);

    initial begin
        hbm_clk = 1'b0;
        forever #5 hbm_clk = ~hbm_clk;
    end

    always @(posedge hbm_clk) begin
        cycles++;
        if (cycles == timeout_cycles) begin
            $display("Timeout: jobs still running after %0d cycles", timeout_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // dma word from a running index, lane number in the top byte
    function automatic logic [dma_data_w-1:0] make_word(input int idx);
        logic [dma_data_w-1:0] w;
        for (int lane = 0; lane < dma_data_w / 32; lane++)
            w[lane*32 +: 32] = {8'(lane), 24'(idx)};
        return w;
    endfunction

    ////////////////////////////////////////
    // dma source and hbm slave
    ////////////////////////////////////////
    initial begin
        dma_cmd_ready  = 1'b0;
        dma_data_valid = 1'b0;
        dma_data       = '0;
        hbm_awready    = 1'b0;
        hbm_wready     = 1'b0;
        words_left     = 0;
        word_idx       = 0;
        forever begin
            @(posedge hbm_clk);
            #1;
            if (dma_fire_n) begin
                words_left--;
                word_idx++;
            end
            if (words_left == 0 && word_q.size() != 0)
                words_left = word_q.pop_front();
            if (words_left == 0)
                dma_data_valid = 1'b0;
            else if (!dma_data_valid || dma_fire_n)
                dma_data_valid = ($random(seed) & 3) != 0;  // hold until taken
            dma_data      = make_word(word_idx);
            dma_cmd_ready = $random(seed) & 1;
            hbm_awready   = $random(seed) & 1;
            hbm_wready    = ($random(seed) & 3) != 0;
        end
    end

    ////////////////////////////////////////
    // handshake monitor and scoreboard
    ////////////////////////////////////////
    always @(negedge hbm_clk) begin
        dma_fire_n = dma_data_valid & dma_data_ready;
        if (hbm_aresetn) begin
            // ready drops once the fifo holds its limit
            exp_ready = fifo_used < fifo_depth - fifo_slack;
            assert (dma_data_ready == exp_ready) else begin
                errors++;
                $display("Mismatch dma_data_ready: got %h, expected %h",
                         dma_data_ready, exp_ready);
            end
            if (dma_cmd_valid && dma_cmd_ready) begin
                cmds_seen++;
                if (cmd_addr_q.size() == 0) begin
                    errors++;
                    $display("DMA command issued with none expected");
                end else begin
                    exp_cmd_addr = cmd_addr_q.pop_front();
                    exp_cmd_len  = cmd_len_q.pop_front();
                    assert (dma_cmd_address == exp_cmd_addr) else begin
                        errors++;
                        $display("Mismatch dma_cmd_address: got %h, expected %h",
                                 dma_cmd_address, exp_cmd_addr);
                    end
                    assert (dma_cmd_length == exp_cmd_len) else begin
                        errors++;
                        $display("Mismatch dma_cmd_length: got %h, expected %h",
                                 dma_cmd_length, exp_cmd_len);
                    end
                end
                word_q.push_back(int'(dma_cmd_length / burst_bytes));
            end
            if (dma_fire_n) begin
                beat_q.push_back(dma_data[hbm_data_w-1:0]);     // low half first
                beat_q.push_back(dma_data[dma_data_w-1:hbm_data_w]);
            end
            if (hbm_awvalid && hbm_awready) begin
                addrs_seen++;
                if (addr_q.size() == 0) begin
                    errors++;
                    $display("HBM write address issued with none expected");
                end else begin
                    exp_addr = addr_q.pop_front();
                    assert (hbm_awaddr == exp_addr) else begin
                        errors++;
                        $display("Mismatch hbm_awaddr: got %h, expected %h", hbm_awaddr, exp_addr);
                    end
                end
            end
            if (hbm_wvalid && hbm_wready) begin
                if (beat_q.size() == 0) begin
                    errors++;
                    $display("HBM write beat issued before its DMA word arrived");
                end else begin
                    exp_beat = beat_q.pop_front();
                    assert (hbm_wdata == exp_beat) else begin
                        errors++;
                        $display("Mismatch hbm_wdata: got %h, expected %h", hbm_wdata, exp_beat);
                    end
                end
                exp_last = (beats_seen % burst_beats) == burst_beats - 1;
                assert (hbm_wlast == exp_last) else begin
                    errors++;
                    $display("Mismatch hbm_wlast: got %h, expected %h", hbm_wlast, exp_last);
                end
                if (beats_seen % (dma_data_w / hbm_data_w) == 1)
                    fifo_used--;                // high half frees the entry
                beats_seen++;
            end
            // done belongs to the cycle after the job's last beat
            assert (hbm_write_done == done_due) else begin
                errors++;
                $display("Mismatch hbm_write_done: got %h, expected %h", hbm_write_done, done_due);
            end
            if (hbm_write_done)
                done_cnt++;
            done_due = hbm_wvalid && hbm_wready && beats_seen == beat_goal;
            if (dma_wr_due)
                fifo_used++;                    // written one cycle after the handshake
            dma_wr_due = dma_fire_n;
        end
    end

    // stalled channels keep valid and payload
    assert property (@(posedge hbm_clk) disable iff (!hbm_aresetn)
        dma_cmd_valid && !dma_cmd_ready |=>
            dma_cmd_valid && $stable(dma_cmd_address) && $stable(dma_cmd_length))
    else begin
        errors++;
        $display("DMA command dropped or changed before it was accepted");
    end

    assert property (@(posedge hbm_clk) disable iff (!hbm_aresetn)
        hbm_awvalid && !hbm_awready |=> hbm_awvalid && $stable(hbm_awaddr))
    else begin
        errors++;
        $display("HBM write address dropped or changed while awready was low");
    end

    assert property (@(posedge hbm_clk) disable iff (!hbm_aresetn)
        hbm_wvalid && !hbm_wready |=> hbm_wvalid && $stable(hbm_wdata) && $stable(hbm_wlast))
    else begin
        errors++;
        $display("HBM write beat dropped or changed while wready was low");
    end

    assert property (@(posedge hbm_clk) disable iff (!hbm_aresetn)
        hbm_write_done |=> !hbm_write_done)
    else begin
        errors++;
        $display("hbm_write_done stayed high for more than one cycle");
    end

    task automatic set_job_addresses(input int j);
        dma_addr_b    = 64'h0000_0001_0000_0000 + 64'(j) * 64'h0010_0000;
        dma_addr_a    = 64'h0000_0002_0000_0000 + 64'(j) * 64'h0010_0000;
        hbm_addr_b    = 33'h0_8000_0000 + 33'(j) * 33'h0_0000_4000;
        araddr_stride = 32'h0000_1000 << j;     // 4k, then 8k per pass
    endtask

    // B linear, A by pass, channel, index in channel
    task automatic queue_job_expectations();
        logic [hbm_addr_w-1:0] low;
        cmd_addr_q.push_back(dma_addr_b);
        cmd_len_q.push_back(data_b_length);
        cmd_addr_q.push_back(dma_addr_a);
        cmd_len_q.push_back(data_a_length);
        for (int k = 0; k < b_bursts; k++)
            addr_q.push_back(hbm_addr_b + hbm_addr_w'(burst_bytes * k));
        for (int p = 0; p < a_passes; p++)
            for (int c = 0; c < chan_num; c++)
                for (int i = 0; i < a_per_chan; i++) begin
                    low = hbm_addr_w'(p) * hbm_addr_w'(araddr_stride)
                        + hbm_addr_w'(burst_bytes * i);
                    addr_q.push_back((hbm_addr_w'(c) << chan_lsb) | (low & low_mask));
                end
    endtask

    task automatic run_job(input int j);
        @(posedge hbm_clk);
        #1;
        set_job_addresses(j);
        queue_job_expectations();
        beat_goal += job_beats;
        start = 1'b1;
        @(posedge hbm_clk);
        #1 start = 1'b0;
        repeat (2) @(posedge hbm_clk);
        @(negedge hbm_clk);
        assert (dma_cmd_valid) else begin
            errors++;
            $display("dma_cmd_valid not raised three cycles after start");
        end
        @(negedge hbm_clk);
        assert (hbm_write_addr_cnt == 0 && hbm_write_data_cnt == 0 && hbm_write_cycle_cnt < 2)
        else begin
            errors++;
            $display("stats counters did not clear when the job started");
        end
        while (!(done_cnt == j + 1 && addr_q.size() == 0))
            @(posedge hbm_clk);
        repeat (3) @(posedge hbm_clk);     // registered stats catch up
        @(negedge hbm_clk);
        assert (hbm_write_addr_cnt == job_bursts) else begin
            errors++;
            $display("Mismatch hbm_write_addr_cnt: got %h, expected %h",
                     hbm_write_addr_cnt, job_bursts);
        end
        assert (hbm_write_data_cnt == job_beats) else begin
            errors++;
            $display("Mismatch hbm_write_data_cnt: got %h, expected %h",
                     hbm_write_data_cnt, job_beats);
        end
        assert (hbm_write_cycle_cnt != 0) else begin
            errors++;
            $display("cycle counter stayed at zero through the job");
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        hbm_aresetn       = 1'b0;
        start             = 1'b0;
        data_a_length     = 32'(a_bursts * burst_bytes);
        data_b_length     = 32'(b_bursts * burst_bytes);
        number_of_samples = 32'(num_samp);
        dimension         = 32'(a_dim);
        number_of_bits    = 32'(a_bits);
        set_job_addresses(0);
        repeat (8) @(posedge hbm_clk);
        #1 hbm_aresetn = 1'b1;
        repeat (4) @(posedge hbm_clk);
        for (int j = 0; j < num_jobs; j++)
            run_job(j);
        assert (done_cnt == num_jobs) else begin
            errors++;
            $display("hbm_write_done pulsed %0d times for %0d jobs", done_cnt, num_jobs);
        end
        assert (beat_q.size() == 0 && cmd_addr_q.size() == 0) else begin
            errors++;
            $display("beats or commands left over at the end of the run");
        end
        $display("commands %0d, addresses %0d, beats %0d, done pulses %0d, errors %0d",
                 cmds_seen, addrs_seen, beats_seen, done_cnt, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
hw/hbm_write_pkg.sv
hw/hbm_aw_gen.sv
hw/hbm_a_layout_walker.sv
hw/dma_width_fifo.sv
hw/hbm_w_ctrl.sv
hw/hbm_wr_stats.sv
hw/hbm_write_top.sv
sim/tb_hbm_write.sv
